// ==== acq_controller.sv ====
// acquisition FSM: pre/post trigger counting, trigger source selection and the event handshake
`timescale 1ns/1ps

module acq_controller import trig_pkg::*; (
   input  logic         clklvds,
   input  logic         reset,
   input  logic         trigger_live,
   input  trig_mode_e   trig_mode,
   input  length_t      pre_length,
   input  length_t      post_length,
   input  logic         ram_wr,
   input  ram_addr_t    wr_address,
   input  logic         low_hit,
   input  logic         high_hit,
   input  logic         event_ready,
   trig_link_if.ctrl    trig_if,
   output logic         run,
   output logic         event_valid,
   output ram_addr_t    trig_address,
   output event_count_t event_count
);

   acq_state_e state;
   trig_mode_e active_mode;  // mode latched when the acquisition started
   length_t    count;        // writes seen in st_pre, then in st_post
   logic       mode_changed;
   logic       arm_hit;      // first edge condition
   logic       fire_hit;     // second edge condition
   logic       pre_full;
   logic       post_last;    // last post-trigger write is on ram_wr now

   assign mode_changed = (trig_mode != active_mode);
   assign arm_hit      = (active_mode == mode_falling) ? high_hit : low_hit;
   assign fire_hit     = (active_mode == mode_falling) ? low_hit : high_hit;
   assign pre_full     = (count >= pre_length);
   assign post_last    = (state == st_post) &&
                         ((post_length == '0) || (ram_wr && (count == post_length - 16'd1)));

   // stop the strobe in the cycle of the last write so none lands in st_done
   assign run         = (state != st_idle) && (state != st_done) && !post_last;
   assign event_valid = (state == st_done);
   assign trig_if.trig_active = (state == st_post);

   always_comb begin
      trig_if.fire    = 1'b0;
      trig_if.fwd_en  = 1'b0;
      trig_if.back_en = 1'b0;
      case (state)
         st_pre: begin
            if (!mode_changed && pre_full && active_mode == mode_auto) begin
               trig_if.fire    = 1'b1; // auto fires straight from the pre window
               trig_if.fwd_en  = 1'b1;
               trig_if.back_en = 1'b1;
            end
         end
         st_fire: begin
            if (!mode_changed && fire_hit) begin
               trig_if.fire    = 1'b1;
               trig_if.fwd_en  = 1'b1;
               trig_if.back_en = 1'b1;
            end
         end
         st_wait_ext: begin
            if (!mode_changed && active_mode == mode_ext) begin
               trig_if.fire    = trig_if.ext_seen;
               trig_if.fwd_en  = trig_if.ext_seen;
               trig_if.back_en = trig_if.ext_seen;
            end else if (!mode_changed) begin
               trig_if.fwd_en  = trig_if.lvds_fwd_seen;  // pass on in the direction it came
               trig_if.back_en = trig_if.lvds_back_seen;
               trig_if.fire    = trig_if.lvds_fwd_seen | trig_if.lvds_back_seen;
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clklvds) begin
      if (reset) begin
         state       <= st_idle;
         active_mode <= mode_off;
         count       <= '0;
         event_count <= '0;
      end else begin
         case (state)
            st_idle: begin
               active_mode <= trig_mode;
               count       <= '0;
               if (trig_mode != mode_off && trigger_live) state <= st_pre;
            end
            st_pre: begin
               if (mode_changed) begin
                  state <= st_idle;
               end else if (!pre_full) begin
                  if (ram_wr) count <= count + 16'd1;
               end else begin
                  count <= '0; // reused for the post window
                  case (active_mode)
                     mode_rising, mode_falling: state <= st_arm;
                     mode_lvds, mode_ext:       state <= st_wait_ext;
                     mode_auto:                 state <= st_post;
                     default:                   state <= st_idle;
                  endcase
               end
            end
            st_arm: begin
               if (mode_changed) state <= st_idle;
               else if (arm_hit) state <= st_fire;
            end
            st_fire, st_wait_ext: begin
               if (mode_changed) state <= st_idle;
               else if (trig_if.fire) state <= st_post;
            end
            st_post: begin
               if (post_last) begin
                  state       <= st_done;
                  event_count <= event_count + 32'd1;
               end else if (ram_wr) begin
                  count <= count + 16'd1;
               end
            end
            st_done: begin
               if (event_ready) state <= st_idle; // readout took the event
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clklvds) begin
      if (trig_if.fire) trig_address <= wr_address; // held through st_done
   end

endmodule

// ==== project.f ====
trig_pkg.sv
trig_link_if.sv
sample_strobe.sv
threshold_detector.sv
trigger_link.sv
acq_controller.sv
triggerer_top.sv
triggerer_asserts.sv
tb_triggerer.sv

// ==== sample_strobe.sv ====
// generates the downsampled ram write strobe and write address while the acquisition runs
`timescale 1ns/1ps

module sample_strobe import trig_pkg::*; (
   input  logic        clklvds,
   input  logic        reset,
   input  logic        run,
   input  downsample_t downsample,
   input  merge_t      downsample_merging,
   output logic        ram_wr,
   output ram_addr_t   wr_address
);

   logic [31:0] ds_cnt;    // counts 1 .. 2^downsample
   merge_t      merge_cnt; // counts ticks 1 .. downsample_merging
   logic        tick;

   assign tick = ds_cnt[downsample]; // bit reaches 1 after 2^downsample cycles

   always_ff @(posedge clklvds) begin
      if (reset) begin
         ds_cnt     <= 32'd1;
         merge_cnt  <= 8'd1;
         ram_wr     <= 1'b0;
         wr_address <= '0;
      end else if (!run) begin
         ds_cnt    <= 32'd1; // restart the phase, address holds
         merge_cnt <= 8'd1;
         ram_wr    <= 1'b0;
      end else if (tick) begin
         ds_cnt <= 32'd1;
         if (merge_cnt == downsample_merging) begin
            merge_cnt  <= 8'd1;
            ram_wr     <= 1'b1;
            wr_address <= wr_address + 10'd1; // wraps modulo 1024
         end else begin
            merge_cnt <= merge_cnt + 8'd1;
            ram_wr    <= 1'b0;
         end
      end else begin
         ds_cnt <= ds_cnt + 32'd1;
         ram_wr <= 1'b0;
      end
   end

endmodule

// ==== tb_triggerer.sv ====
// directed testbench for triggerer_top, compiled with project.f and run with tb_triggerer as top
`timescale 1ns/1ps

module tb_triggerer import trig_pkg::*; ();

   localparam int num_samples     = 8;
   localparam int ds_exp          = 2;
   localparam int merge_factor    = 3;
   localparam int write_period    = (2 ** ds_exp) * merge_factor; // cycles between ram writes
   localparam int pre_len         = 4;
   localparam int post_len        = 6;
   localparam int arm_wait        = (pre_len + 3) * write_period; // pre window is full by then
   localparam int event_cycles    = (pre_len + post_len + 2) * write_period;
   localparam int num_events      = 8;
   localparam int watchdog_cycles = 16 + 2 * num_events * (event_cycles + arm_wait) + 400;

   logic         clklvds;
   logic         reset;
   sample_t      samples [num_samples];
   sample_t      lower_thresh;
   sample_t      upper_thresh;
   length_t      pre_length;
   length_t      post_length;
   trig_mode_e   trig_mode;
   logic         trigger_live;
   downsample_t  downsample;
   merge_t       downsample_merging;
   logic         lvdsin_trig, lvdsin_trig_b, exttrigin;
   logic         event_ready;
   logic         ram_wr;
   ram_addr_t    ram_wr_address;
   logic         lvdsout_trig, lvdsout_trig_b, auxout;
   logic         event_valid;
   ram_addr_t    trig_address;
   event_count_t event_count;
   event_count_t expected_events; // events accepted so far

   triggerer_top #(
      .num_samples (num_samples)
   ) i_triggerer_top (
      .clklvds            (clklvds),
      .reset              (reset),
      .samples            (samples),
      .lower_thresh       (lower_thresh),
      .upper_thresh       (upper_thresh),
      .pre_length         (pre_length),
      .post_length        (post_length),
      .trig_mode          (trig_mode),
      .trigger_live       (trigger_live),
      .downsample         (downsample),
      .downsample_merging (downsample_merging),
      .lvdsin_trig        (lvdsin_trig),
      .lvdsin_trig_b      (lvdsin_trig_b),
      .exttrigin          (exttrigin),
      .event_ready        (event_ready),
      .ram_wr             (ram_wr),
      .ram_wr_address     (ram_wr_address),
      .lvdsout_trig       (lvdsout_trig),
      .lvdsout_trig_b     (lvdsout_trig_b),
      .auxout             (auxout),
      .event_valid        (event_valid),
      .trig_address       (trig_address),
      .event_count        (event_count)
   );

   initial begin
      clklvds = 1'b0;
      forever #4 clklvds = ~clklvds; // 8 ns period
   end

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("Test failures found");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic compare_addr(string test, ram_addr_t exp, ram_addr_t act);
      if (act !== exp) fail_run($sformatf("Fail %s: expected 0x%0h, actual 0x%0h", test, exp, act));
   endtask

   task automatic compare_count(string test, event_count_t exp, event_count_t act);
      if (act !== exp) fail_run($sformatf("Fail %s: expected %0d, actual %0d", test, exp, act));
   endtask

   task automatic compare_bit(string test, logic exp, logic act);
      if (act !== exp) fail_run($sformatf("Fail %s: expected %b, actual %b", test, exp, act));
   endtask

   task automatic next_drive_slot();
      @(posedge clklvds);
      #1;
   endtask

   task automatic fill_band();
      for (int i = 0; i < num_samples; i++)
         samples[i] = sample_t'(int'($urandom % 201) - 100); // inside -100 .. 100
   endtask

   task automatic spike_lane(sample_t value);
      next_drive_slot();
      fill_band();
      samples[$urandom % num_samples] = value; // one lane out of band for one cycle
   endtask

   task automatic quiet_cycles(string test, int n);
      repeat (n) begin
         next_drive_slot();
         fill_band();
         @(negedge clklvds);
         compare_bit(test, 1'b0, lvdsout_trig);
         compare_bit(test, 1'b0, lvdsout_trig_b);
         compare_bit(test, 1'b0, event_valid);
      end
   endtask

   task automatic expect_idle(string test, int n);
      repeat (n) begin
         @(negedge clklvds);
         compare_bit(test, 1'b0, ram_wr);
         compare_bit(test, 1'b0, event_valid);
      end
   endtask

   task automatic expect_trigger(string test, logic exp_fwd, logic exp_back);
      int waited;
      waited = 0;
      @(negedge clklvds);
      while (!(lvdsout_trig || lvdsout_trig_b)) begin
         waited++;
         if (waited > 2 * write_period) fail_run($sformatf("no trigger pulse came in test %s", test));
         @(negedge clklvds);
      end
      repeat (2) begin // both cycles of the pulse
         compare_bit(test, exp_fwd, lvdsout_trig);
         compare_bit(test, exp_back, lvdsout_trig_b);
         @(negedge clklvds);
      end
   endtask

   task automatic wait_event_valid(string test);
      int waited;
      waited = 0;
      @(negedge clklvds);
      while (!event_valid) begin
         waited++;
         if (waited > event_cycles) fail_run($sformatf("event_valid never rose in test %s", test));
         @(negedge clklvds);
      end
   endtask

   task automatic accept_event(string test);
      wait_event_valid(test);
      expected_events++;
      compare_count(test, expected_events, event_count);
      next_drive_slot();
      event_ready = 1'b1;
      trig_mode   = mode_off; // nothing restarts after the handshake
      next_drive_slot();
      event_ready = 1'b0;
      @(negedge clklvds);
      compare_bit(test, 1'b0, event_valid);
   endtask

   task automatic write_rate_test();
      int        gap;
      int        pulses;
      ram_addr_t last_addr;
      gap       = 0;
      pulses    = 0;
      last_addr = '0;
      next_drive_slot();
      trig_mode = mode_auto;
      while (pulses < 5) begin
         @(negedge clklvds);
         gap++;
         if (gap > 2 * write_period) fail_run("ram_wr stopped pulsing in test write_rate");
         if (ram_wr) begin
            if (pulses > 0) begin
               compare_count("write_rate", event_count_t'(write_period), event_count_t'(gap));
               compare_addr("write_rate", last_addr + 10'd1, ram_wr_address);
            end
            last_addr = ram_wr_address;
            gap       = 0;
            pulses++;
         end
      end
      accept_event("write_rate");
   endtask

   task automatic auto_event_test();
      int        pre_writes;
      int        post_writes;
      int        cycles;
      logic      fired;
      ram_addr_t exp_addr;
      pre_writes  = 0;
      post_writes = 0;
      cycles      = 0;
      fired       = 1'b0;
      next_drive_slot();
      trig_mode = mode_auto;
      do begin
         @(negedge clklvds);
         cycles++;
         if (cycles > event_cycles + write_period) fail_run("auto event never completed");
         if (!fired && lvdsout_trig) begin
            fired = 1'b1;
            compare_bit("auto_event_back", 1'b1, lvdsout_trig_b);
         end
         if (fired && !event_valid) begin
            compare_bit("auto_event_aux", 1'b1, auxout);
            if (ram_wr) post_writes++;
         end else if (!fired && ram_wr) begin
            pre_writes++;
         end
      end while (!event_valid);
      compare_bit("auto_event_fired", 1'b1, fired);
      compare_bit("auto_event_pre", 1'b1, pre_writes >= pre_len);
      compare_count("auto_event_post", event_count_t'(post_len), event_count_t'(post_writes));
      exp_addr = trig_address + ram_addr_t'(post_len); // wraps modulo 1024
      compare_addr("auto_event_addr", exp_addr, ram_wr_address);
      accept_event("auto_event");
   endtask

   task automatic threshold_test();
      next_drive_slot();
      trig_mode = mode_rising;
      quiet_cycles("rising_band", arm_wait);
      spike_lane(lower_thresh - 12'sd20);
      spike_lane(upper_thresh + 12'sd20);
      next_drive_slot();
      fill_band();
      expect_trigger("rising", 1'b1, 1'b1);
      accept_event("rising");
      next_drive_slot();
      trig_mode = mode_falling;
      quiet_cycles("falling_band", arm_wait);
      spike_lane(lower_thresh - 12'sd20); // a rise must not fire falling mode
      spike_lane(upper_thresh + 12'sd20);
      quiet_cycles("falling_rise_only", 40);
      spike_lane(upper_thresh + 12'sd20);
      spike_lane(lower_thresh - 12'sd20);
      next_drive_slot();
      fill_band();
      expect_trigger("falling", 1'b1, 1'b1);
      accept_event("falling");
   endtask

   task automatic link_event(string test, trig_mode_e mode, logic [2:0] pins,
                             logic exp_fwd, logic exp_back);
      next_drive_slot();
      trig_mode = mode;
      quiet_cycles(test, arm_wait);
      next_drive_slot();
      {lvdsin_trig, lvdsin_trig_b, exttrigin} = pins;
      next_drive_slot();
      {lvdsin_trig, lvdsin_trig_b, exttrigin} = 3'b000;
      expect_trigger(test, exp_fwd, exp_back);
      accept_event(test);
   endtask

   task automatic backpressure_test();
      ram_addr_t held_addr;
      ram_addr_t held_trig;
      next_drive_slot();
      trig_mode = mode_auto;
      wait_event_valid("backpressure");
      held_addr = ram_wr_address;
      held_trig = trig_address;
      repeat (50) begin
         @(negedge clklvds);
         compare_bit("backpressure_valid", 1'b1, event_valid);
         compare_bit("backpressure_write", 1'b0, ram_wr);
         compare_addr("backpressure_addr", held_addr, ram_wr_address);
         compare_addr("backpressure_trig", held_trig, trig_address);
      end
      accept_event("backpressure");
      expect_idle("mode_off", 100);
      next_drive_slot();
      trigger_live = 1'b0;
      trig_mode    = mode_auto;
      expect_idle("not_live", 100);
      compare_count("idle_count", expected_events, event_count);
      next_drive_slot();
      trig_mode    = mode_off;
      trigger_live = 1'b1;
   endtask

   initial begin
      repeat (watchdog_cycles) @(posedge clklvds);
      fail_run($sformatf("watchdog expired after %0d cycles, a test is stuck", watchdog_cycles));
   end

   initial begin
      wait (i_triggerer_top.i_triggerer_asserts.fail_count != 0);
      fail_run("a concurrent assertion on the DUT ports failed");
   end

   initial begin
      void'($urandom(26));
      reset              = 1'b1;
      trig_mode          = mode_off;
      trigger_live       = 1'b1;
      event_ready        = 1'b0;
      lvdsin_trig        = 1'b0;
      lvdsin_trig_b      = 1'b0;
      exttrigin          = 1'b0;
      lower_thresh       = -12'sd100;
      upper_thresh       = 12'sd100;
      pre_length         = length_t'(pre_len);
      post_length        = length_t'(post_len);
      downsample         = downsample_t'(ds_exp);
      downsample_merging = merge_t'(merge_factor);
      expected_events    = '0;
      fill_band();
      repeat (16) @(posedge clklvds);
      #1;
      reset = 1'b0;
      @(negedge clklvds);
      compare_bit("reset_wr", 1'b0, ram_wr);
      compare_bit("reset_fwd", 1'b0, lvdsout_trig);
      compare_bit("reset_back", 1'b0, lvdsout_trig_b);
      compare_bit("reset_aux", 1'b0, auxout);
      compare_bit("reset_valid", 1'b0, event_valid);
      compare_addr("reset_addr", '0, ram_wr_address);
      compare_count("reset_count", '0, event_count);
      write_rate_test();
      auto_event_test();
      threshold_test();
      link_event("lvds_fwd", mode_lvds, 3'b100, 1'b1, 1'b0);
      link_event("lvds_back", mode_lvds, 3'b010, 1'b0, 1'b1);
      link_event("sma_ext", mode_ext, 3'b001, 1'b1, 1'b1);
      backpressure_test();
      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== threshold_detector.sv ====
// compares all sample lanes against the lower and upper thresholds, one cycle latency
`timescale 1ns/1ps

module threshold_detector import trig_pkg::*; #(
   parameter int num_samples = default_num_samples
) (
   input  logic    clklvds,
   input  logic    reset,
   input  sample_t samples [num_samples],
   input  sample_t lower_thresh,
   input  sample_t upper_thresh,
   output logic    low_hit,
   output logic    high_hit
);

   logic [num_samples-1:0] below; // per lane, under lower_thresh
   logic [num_samples-1:0] above; // per lane, over upper_thresh

   always_comb begin
      for (int i = 0; i < num_samples; i++) begin
         below[i] = (samples[i] < lower_thresh); // signed, both operands sample_t
         above[i] = (samples[i] > upper_thresh);
      end
   end

   always_ff @(posedge clklvds) begin
      if (reset) begin
         low_hit  <= 1'b0;
         high_hit <= 1'b0;
      end else begin
         low_hit  <= |below; // any lane counts
         high_hit <= |above;
      end
   end

endmodule

// ==== trig_link_if.sv ====
// trigger request and received-trigger signals between the acquisition FSM and the link block
`timescale 1ns/1ps

interface trig_link_if;

   logic fire;           // one-cycle trigger request
   logic fwd_en;         // signal forward on lvdsout_trig
   logic back_en;        // signal backward on lvdsout_trig_b
   logic trig_active;    // high while recording post-trigger samples
   logic lvds_fwd_seen;  // registered lvdsin_trig
   logic lvds_back_seen; // registered lvdsin_trig_b
   logic ext_seen;       // synchronized sma input

   modport ctrl (
      output fire, fwd_en, back_en, trig_active,
      input  lvds_fwd_seen, lvds_back_seen, ext_seen
   );

   modport link (
      input  fire, fwd_en, back_en, trig_active,
      output lvds_fwd_seen, lvds_back_seen, ext_seen
   );

endinterface

// ==== trig_pkg.sv ====
// shared types, state encodings and default sizes of the acquisition trigger, imported by the rtl
package trig_pkg;

   localparam int default_num_samples = 40; // sample lanes per clklvds cycle on the full board

   typedef logic signed [11:0] sample_t;      // one adc sample
   typedef logic [9:0]         ram_addr_t;    // ram write address, wraps at 1024
   typedef logic [15:0]        length_t;      // pre/post trigger length in writes
   typedef logic [7:0]         merge_t;       // ticks merged into one ram write
   typedef logic [4:0]         downsample_t;  // log2 of the downsample factor
   typedef logic [31:0]        event_count_t;

   // trigger source selection
   typedef enum logic [2:0] {
      mode_off     = 3'd0,
      mode_rising  = 3'd1, // threshold, low then high
      mode_falling = 3'd2, // threshold, high then low
      mode_lvds    = 3'd3, // neighbor board over lvds
      mode_auto    = 3'd4, // unconditional capture
      mode_ext     = 3'd5  // back-panel sma
   } trig_mode_e;

   // acquisition controller states
   typedef enum logic [2:0] {
      st_idle     = 3'd0,
      st_pre      = 3'd1, // filling the pre-trigger window
      st_arm      = 3'd2, // waiting for the first edge condition
      st_fire     = 3'd3, // waiting for the second edge condition
      st_wait_ext = 3'd4, // waiting for lvds or sma trigger
      st_post     = 3'd5, // recording after the trigger
      st_done     = 3'd6  // event offered to readout
   } acq_state_e;

endpackage

// ==== trigger_link.sv ====
// receives neighbor and sma triggers and drives the lvds and back-panel trigger outputs
`timescale 1ns/1ps

module trigger_link (
   input  logic      clklvds,
   input  logic      reset,
   input  logic      lvdsin_trig,
   input  logic      lvdsin_trig_b,
   input  logic      exttrigin,
   trig_link_if.link trig_if,
   output logic      lvdsout_trig,
   output logic      lvdsout_trig_b,
   output logic      auxout
);

   logic ext_meta;  // first synchronizer stage, exttrigin is asynchronous
   logic fwd_hold;  // second cycle of a forward pulse
   logic back_hold; // second cycle of a backward pulse
   logic fire_fwd;
   logic fire_back;

   assign fire_fwd  = trig_if.fire & trig_if.fwd_en;
   assign fire_back = trig_if.fire & trig_if.back_en;

   always_ff @(posedge clklvds) begin
      if (reset) begin
         trig_if.lvds_fwd_seen  <= 1'b0;
         trig_if.lvds_back_seen <= 1'b0;
         ext_meta               <= 1'b0;
         trig_if.ext_seen       <= 1'b0;
      end else begin
         trig_if.lvds_fwd_seen  <= lvdsin_trig;
         trig_if.lvds_back_seen <= lvdsin_trig_b;
         ext_meta               <= exttrigin;
         trig_if.ext_seen       <= ext_meta;
      end
   end

   // each request becomes a two-cycle pulse so the neighbor cannot miss it
   always_ff @(posedge clklvds) begin
      if (reset) begin
         fwd_hold       <= 1'b0;
         back_hold      <= 1'b0;
         lvdsout_trig   <= 1'b0;
         lvdsout_trig_b <= 1'b0;
      end else begin
         fwd_hold       <= fire_fwd;
         back_hold      <= fire_back;
         lvdsout_trig   <= fire_fwd | fwd_hold;
         lvdsout_trig_b <= fire_back | back_hold;
      end
   end

   assign auxout = trig_if.trig_active; // back-panel sma out, high during post-trigger recording

endmodule

// ==== triggerer_asserts.sv ====
// port-level concurrent checks of triggerer_top, attached to every instance by the bind below
`timescale 1ns/1ps

module triggerer_asserts import trig_pkg::*; (
   input logic      clklvds,
   input logic      reset,
   input logic      ram_wr,
   input logic      event_valid,
   input logic      event_ready,
   input ram_addr_t trig_address,
   input logic      lvdsout_trig,
   input logic      lvdsout_trig_b
);

   int unsigned fail_count = 0; // failed assertions so far

   no_write_pending: assert property (@(posedge clklvds) disable iff (reset)
      event_valid |-> !ram_wr)
      else begin
         fail_count++;
         $error("ram_wr pulsed while event_valid was high");
      end

   // readout may take its time, the address must not move meanwhile
   trig_address_held: assert property (@(posedge clklvds) disable iff (reset)
      event_valid && !event_ready |=> $stable(trig_address))
      else begin
         fail_count++;
         $error("trig_address changed while the event waited for readout");
      end

   fwd_pulse_width: assert property (@(posedge clklvds) disable iff (reset)
      $rose(lvdsout_trig) |=> lvdsout_trig ##1 !lvdsout_trig)
      else begin
         fail_count++;
         $error("lvdsout_trig pulse was not two cycles long");
      end

   back_pulse_width: assert property (@(posedge clklvds) disable iff (reset)
      $rose(lvdsout_trig_b) |=> lvdsout_trig_b ##1 !lvdsout_trig_b)
      else begin
         fail_count++;
         $error("lvdsout_trig_b pulse was not two cycles long");
      end

endmodule

bind triggerer_top triggerer_asserts i_triggerer_asserts (.*);

// ==== triggerer_top.sv ====
// top level of the acquisition trigger, connects strobe, threshold, link and controller blocks
`timescale 1ns/1ps

module triggerer_top import trig_pkg::*; #(
   parameter int num_samples = default_num_samples
) (
   input  logic         clklvds,
   input  logic         reset,
   input  sample_t      samples [num_samples],
   input  sample_t      lower_thresh,
   input  sample_t      upper_thresh,
   input  length_t      pre_length,
   input  length_t      post_length,
   input  trig_mode_e   trig_mode,
   input  logic         trigger_live,
   input  downsample_t  downsample,
   input  merge_t       downsample_merging,
   input  logic         lvdsin_trig,
   input  logic         lvdsin_trig_b,
   input  logic         exttrigin,
   input  logic         event_ready,
   output logic         ram_wr,
   output ram_addr_t    ram_wr_address,
   output logic         lvdsout_trig,
   output logic         lvdsout_trig_b,
   output logic         auxout,
   output logic         event_valid,
   output ram_addr_t    trig_address,
   output event_count_t event_count
);

   logic run;      // strobe enable from the controller
   logic low_hit;
   logic high_hit;

   trig_link_if i_link_if ();

   sample_strobe i_sample_strobe (
      .clklvds            (clklvds),
      .reset              (reset),
      .run                (run),
      .downsample         (downsample),
      .downsample_merging (downsample_merging),
      .ram_wr             (ram_wr),
      .wr_address         (ram_wr_address)
   );

   threshold_detector #(
      .num_samples (num_samples)
   ) i_threshold_detector (
      .clklvds      (clklvds),
      .reset        (reset),
      .samples      (samples),
      .lower_thresh (lower_thresh),
      .upper_thresh (upper_thresh),
      .low_hit      (low_hit),
      .high_hit     (high_hit)
   );

   trigger_link i_trigger_link (
      .clklvds        (clklvds),
      .reset          (reset),
      .lvdsin_trig    (lvdsin_trig),
      .lvdsin_trig_b  (lvdsin_trig_b),
      .exttrigin      (exttrigin),
      .trig_if        (i_link_if.link),
      .lvdsout_trig   (lvdsout_trig),
      .lvdsout_trig_b (lvdsout_trig_b),
      .auxout         (auxout)
   );

   acq_controller i_acq_controller (
      .clklvds      (clklvds),
      .reset        (reset),
      .trigger_live (trigger_live),
      .trig_mode    (trig_mode),
      .pre_length   (pre_length),
      .post_length  (post_length),
      .ram_wr       (ram_wr),
      .wr_address   (ram_wr_address),
      .low_hit      (low_hit),
      .high_hit     (high_hit),
      .event_ready  (event_ready),
      .trig_if      (i_link_if.ctrl),
      .run          (run),
      .event_valid  (event_valid),
      .trig_address (trig_address),
      .event_count  (event_count)
   );

endmodule
